//--- dcache_pkg.sv
// Data-memory widths, size and op encodings, request/bus structs, cause and AMO codes
`default_nettype none

package dcache_pkg;

    localparam int XLEN     = 64;
    localparam int STRB_W   = XLEN / 8;
    localparam int OFFSET_W = $clog2(STRB_W);

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [1:0]          size_t;
    typedef logic [4:0]          amo_funct_t;  // Instruction bits 31:27

    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;
    localparam size_t SIZE_D = 2'd3;

    typedef enum logic [2:0] {
        MEM_LOAD,
        MEM_LR,
        MEM_STORE,
        MEM_SC,
        MEM_AMO
    } mem_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_R,
        ST_AMO,
        ST_WAIT_W
    } ctrl_state_t;

    typedef struct packed {
        mem_op_t    op;
        size_t      size;
        logic       is_unsigned;
        amo_funct_t amo_funct;
        xlen_t      address;
        xlen_t      value;
    } mem_req_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] cause;
        xlen_t      tval;
    } exception_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } bus_addr_t;

    typedef struct packed {
        logic  valid;
        xlen_t data;
        strb_t strb;
    } bus_w_t;

    localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;

    localparam amo_funct_t AMO_SWAP = 5'b00001;
    localparam amo_funct_t AMO_ADD  = 5'b00000;
    localparam amo_funct_t AMO_XOR  = 5'b00100;
    localparam amo_funct_t AMO_AND  = 5'b01100;
    localparam amo_funct_t AMO_OR   = 5'b01000;
    localparam amo_funct_t AMO_MIN  = 5'b10000;
    localparam amo_funct_t AMO_MAX  = 5'b10100;
    localparam amo_funct_t AMO_MINU = 5'b11000;
    localparam amo_funct_t AMO_MAXU = 5'b11100;

endpackage

`default_nettype wire

//--- lsu_align.sv
// Alignment check, store strobe and shift, load extraction with zero or sign extension
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  wire dcache_pkg::mem_req_t in_req,
    input  wire dcache_pkg::mem_req_t cur_req,
    input  wire dcache_pkg::xlen_t    store_value,
    input  wire dcache_pkg::xlen_t    r_data,
    output logic                      misaligned,
    output dcache_pkg::strb_t         strb,
    output dcache_pkg::xlen_t         store_data,
    output dcache_pkg::xlen_t         load_value
);

    dcache_pkg::offset_t             in_off;
    dcache_pkg::offset_t             cur_off;
    logic [dcache_pkg::OFFSET_W+2:0] shamt;    // Byte offset in bits
    dcache_pkg::xlen_t               shifted;
    logic                            sext;

    assign in_off  = in_req.address[dcache_pkg::OFFSET_W-1:0];
    assign cur_off = cur_req.address[dcache_pkg::OFFSET_W-1:0];
    assign shamt   = {cur_off, 3'b000};

    assign store_data = store_value << shamt;
    assign shifted    = r_data >> shamt;        // Addressed bytes land at bit 0

    // AMO originals are always signed so word min/max compare correctly
    assign sext = !cur_req.is_unsigned || cur_req.op == dcache_pkg::MEM_AMO;

    always_comb begin
        case (in_req.size)
            dcache_pkg::SIZE_B: misaligned = 1'b0;
            dcache_pkg::SIZE_H: misaligned = in_off[0];
            dcache_pkg::SIZE_W: misaligned = |in_off[1:0];
            dcache_pkg::SIZE_D: misaligned = |in_off;
        endcase
    end

    always_comb begin
        case (cur_req.size)
            dcache_pkg::SIZE_B: strb = dcache_pkg::strb_t'(1) << cur_off;
            dcache_pkg::SIZE_H: strb = dcache_pkg::strb_t'(3) << cur_off;
            dcache_pkg::SIZE_W: strb = dcache_pkg::strb_t'(15) << cur_off;
            dcache_pkg::SIZE_D: strb = '1;
        endcase
    end

    always_comb begin
        case (cur_req.size)
            dcache_pkg::SIZE_B: begin
                load_value = {{(dcache_pkg::XLEN-8){sext & shifted[7]}}, shifted[7:0]};
            end
            dcache_pkg::SIZE_H: begin
                load_value = {{(dcache_pkg::XLEN-16){sext & shifted[15]}}, shifted[15:0]};
            end
            dcache_pkg::SIZE_W: begin
                load_value = {{(dcache_pkg::XLEN-32){sext & shifted[31]}}, shifted[31:0]};
            end
            dcache_pkg::SIZE_D: load_value = shifted;  // is_unsigned has no effect
        endcase
    end

endmodule

`default_nettype wire

//--- amo_alu.sv
// RISC-V AMO swap, add, logic and signed/unsigned min/max on 64-bit operands
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
    input  wire dcache_pkg::xlen_t      original,
    input  wire dcache_pkg::xlen_t      operand,
    input  wire dcache_pkg::amo_funct_t funct,
    output dcache_pkg::xlen_t           result
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(original) < $signed(operand);
    assign lt_unsigned = original < operand;

    always_comb begin
        unique case (funct)
            dcache_pkg::AMO_SWAP: result = operand;
            dcache_pkg::AMO_ADD:  result = original + operand;
            dcache_pkg::AMO_XOR:  result = original ^ operand;
            dcache_pkg::AMO_AND:  result = original & operand;
            dcache_pkg::AMO_OR:   result = original | operand;
            dcache_pkg::AMO_MIN:  result = lt_signed ? original : operand;
            dcache_pkg::AMO_MAX:  result = lt_signed ? operand : original;
            dcache_pkg::AMO_MINU: result = lt_unsigned ? original : operand;
            dcache_pkg::AMO_MAXU: result = lt_unsigned ? operand : original;
            default:              result = operand;
        endcase
    end

    always_comb begin
        assert (funct inside {dcache_pkg::AMO_SWAP, dcache_pkg::AMO_ADD, dcache_pkg::AMO_XOR,
                              dcache_pkg::AMO_AND, dcache_pkg::AMO_OR, dcache_pkg::AMO_MIN,
                              dcache_pkg::AMO_MAX, dcache_pkg::AMO_MINU, dcache_pkg::AMO_MAXU})
            else $error("amo_alu: unknown AMO function %b", funct);
    end

endmodule

`default_nettype wire

//--- bus_issue.sv
// AR, AW and W channel registers with valid held until ready
`timescale 1ns/1ps
`default_nettype none

module bus_issue (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       issue_read,
    input  wire                       issue_write,
    input  wire dcache_pkg::xlen_t    addr,
    input  wire dcache_pkg::xlen_t    data,
    input  wire dcache_pkg::strb_t    strb,
    input  wire                       ar_ready,
    input  wire                       aw_ready,
    input  wire                       w_ready,
    output dcache_pkg::bus_addr_t     ar,
    output dcache_pkg::bus_addr_t     aw,
    output dcache_pkg::bus_w_t        w,
    output logic                      busy
);

    logic              ar_valid;
    logic              aw_valid;
    logic              w_valid;
    dcache_pkg::xlen_t addr_q;    // One transaction at a time, so AR and AW share it
    dcache_pkg::xlen_t data_q;
    dcache_pkg::strb_t strb_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            if (issue_read) ar_valid <= 1'b1;
            else if (ar_ready) ar_valid <= 1'b0;
            if (issue_write) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
            end else begin
                if (aw_ready) aw_valid <= 1'b0;  // AW and W finish independently
                if (w_ready) w_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_read || issue_write) addr_q <= addr;
        if (issue_write) begin
            data_q <= data;
            strb_q <= strb;
        end
    end

    assign ar   = '{valid: ar_valid, addr: addr_q};
    assign aw   = '{valid: aw_valid, addr: addr_q};
    assign w    = '{valid: w_valid, data: data_q, strb: strb_q};
    assign busy = ar_valid | aw_valid | w_valid;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rstn)
        (issue_read || issue_write) |-> !busy);
    a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
        ar.valid && !ar_ready |=> ar.valid && $stable(ar.addr));
    a_aw_stable: assert property (@(posedge clk) disable iff (!rstn)
        aw.valid && !aw_ready |=> aw.valid && $stable(aw.addr));
    a_w_stable: assert property (@(posedge clk) disable iff (!rstn)
        w.valid && !w_ready |=> w.valid && $stable(w.data) && $stable(w.strb));

endmodule

`default_nettype wire

//--- uncached_ctrl.sv
// Request latch, response and exception generation, and the operation FSM
`timescale 1ns/1ps
`default_nettype none

module uncached_ctrl (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       req_valid,
    input  wire dcache_pkg::mem_req_t req,
    input  wire                       misaligned,
    input  wire dcache_pkg::xlen_t    load_value,
    input  wire dcache_pkg::xlen_t    amo_result,
    input  wire                       r_valid,
    input  wire                       b_valid,
    input  wire                       bus_busy,
    output logic                      req_ready,
    output dcache_pkg::mem_req_t      cur_req,
    output dcache_pkg::xlen_t         store_value,
    output logic                      issue_read,
    output logic                      issue_write,
    output dcache_pkg::xlen_t         bus_addr,
    output logic                      resp_valid,
    output dcache_pkg::xlen_t         resp_value,
    output dcache_pkg::exception_t    resp_exception
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::mem_req_t    lat_req;
    logic                    pend_resp;   // Response goes out on the next edge
    logic                    pend_exc;
    logic                    exc_valid;
    logic [3:0]              exc_cause;
    dcache_pkg::xlen_t       exc_tval;
    logic                    accept;
    logic                    is_write;

    assign req_ready   = state == dcache_pkg::ST_IDLE && !pend_resp && !pend_exc;
    assign accept      = req_valid && req_ready;
    assign is_write    = cur_req.op == dcache_pkg::MEM_STORE || cur_req.op == dcache_pkg::MEM_SC;
    assign store_value = cur_req.op == dcache_pkg::MEM_AMO ? amo_result : cur_req.value;
    assign bus_addr    = cur_req.address;

    assign resp_exception = '{valid: exc_valid, cause: exc_cause, tval: exc_tval};

    // Word AMO operand sign-extended like the loaded original
    always_comb begin
        lat_req = req;
        if (req.op == dcache_pkg::MEM_AMO && req.size == dcache_pkg::SIZE_W) begin
            lat_req.value = {{(dcache_pkg::XLEN-32){req.value[31]}}, req.value[31:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req   <= lat_req;
            exc_tval  <= req.address;
            exc_cause <= (req.op == dcache_pkg::MEM_LOAD || req.op == dcache_pkg::MEM_LR) ?
                         dcache_pkg::CAUSE_LOAD_MISALIGNED : dcache_pkg::CAUSE_STORE_MISALIGNED;
        end
        if (state == dcache_pkg::ST_WAIT_R && r_valid) resp_value <= load_value;
        // Store and SC answer zero, AMO keeps the loaded value
        if (state == dcache_pkg::ST_WAIT_W && b_valid && cur_req.op != dcache_pkg::MEM_AMO) begin
            resp_value <= '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= dcache_pkg::ST_IDLE;
            pend_resp   <= 1'b0;
            pend_exc    <= 1'b0;
            exc_valid   <= 1'b0;
            resp_valid  <= 1'b0;
            issue_read  <= 1'b0;
            issue_write <= 1'b0;
        end else begin
            resp_valid  <= 1'b0;
            exc_valid   <= 1'b0;
            issue_read  <= 1'b0;
            issue_write <= 1'b0;
            unique case (state)
                dcache_pkg::ST_IDLE: begin
                    if (pend_resp) begin
                        resp_valid <= 1'b1;
                        pend_resp  <= 1'b0;
                    end else if (pend_exc) begin
                        exc_valid <= 1'b1;
                        pend_exc  <= 1'b0;
                    end else if (accept) begin
                        if (misaligned) pend_exc <= 1'b1;  // No bus traffic
                        else state <= dcache_pkg::ST_ISSUE;
                    end
                end
                dcache_pkg::ST_ISSUE: begin
                    if (!bus_busy) begin
                        if (is_write) begin
                            issue_write <= 1'b1;
                            state       <= dcache_pkg::ST_WAIT_W;
                        end else begin
                            issue_read <= 1'b1;  // Load, LR and AMO read phase
                            state      <= dcache_pkg::ST_WAIT_R;
                        end
                    end
                end
                dcache_pkg::ST_WAIT_R: begin
                    if (r_valid) begin
                        if (cur_req.op == dcache_pkg::MEM_AMO) begin
                            state <= dcache_pkg::ST_AMO;
                        end else begin
                            pend_resp <= 1'b1;
                            state     <= dcache_pkg::ST_IDLE;
                        end
                    end
                end
                dcache_pkg::ST_AMO: begin
                    if (!bus_busy) begin
                        issue_write <= 1'b1;
                        state       <= dcache_pkg::ST_WAIT_W;
                    end
                end
                dcache_pkg::ST_WAIT_W: begin
                    if (b_valid) begin
                        pend_resp <= 1'b1;
                        state     <= dcache_pkg::ST_IDLE;
                    end
                end
                default: state <= dcache_pkg::ST_IDLE;
            endcase
        end
    end

    a_single_resp: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && resp_exception.valid));
    a_r_in_wait: assert property (@(posedge clk) disable iff (!rstn)
        r_valid |-> state == dcache_pkg::ST_WAIT_R);

endmodule

`default_nettype wire

//--- dcache_uncached.sv
// Uncached data-memory unit top, CPU request port and reduced AXI memory port
`timescale 1ns/1ps
`default_nettype none

module dcache_uncached (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       req_valid,
    input  wire dcache_pkg::mem_req_t req,
    output logic                      req_ready,
    output logic                      resp_valid,
    output dcache_pkg::xlen_t         resp_value,
    output dcache_pkg::exception_t    resp_exception,
    output dcache_pkg::bus_addr_t     ar,
    output dcache_pkg::bus_addr_t     aw,
    output dcache_pkg::bus_w_t        w,
    input  wire                       ar_ready,
    input  wire                       aw_ready,
    input  wire                       w_ready,
    input  wire                       r_valid,
    input  wire dcache_pkg::xlen_t    r_data,
    input  wire                       b_valid
);

    dcache_pkg::mem_req_t cur_req;
    dcache_pkg::xlen_t    store_value;
    dcache_pkg::xlen_t    store_data;
    dcache_pkg::xlen_t    load_value;
    dcache_pkg::xlen_t    amo_result;
    dcache_pkg::xlen_t    bus_addr;
    dcache_pkg::strb_t    strb;
    logic                 misaligned;
    logic                 issue_read;
    logic                 issue_write;
    logic                 bus_busy;

    lsu_align u_align (
        .in_req      (req),
        .cur_req     (cur_req),
        .store_value (store_value),
        .r_data      (r_data),
        .misaligned  (misaligned),
        .strb        (strb),
        .store_data  (store_data),
        .load_value  (load_value)
    );

    amo_alu u_amo (
        .original (resp_value),         // Loaded value held from ST_WAIT_R
        .operand  (cur_req.value),
        .funct    (cur_req.amo_funct),
        .result   (amo_result)
    );

    bus_issue u_bus (
        .clk         (clk),
        .rstn        (rstn),
        .issue_read  (issue_read),
        .issue_write (issue_write),
        .addr        (bus_addr),
        .data        (store_data),
        .strb        (strb),
        .ar_ready    (ar_ready),
        .aw_ready    (aw_ready),
        .w_ready     (w_ready),
        .ar          (ar),
        .aw          (aw),
        .w           (w),
        .busy        (bus_busy)
    );

    uncached_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req            (req),
        .misaligned     (misaligned),
        .load_value     (load_value),
        .amo_result     (amo_result),
        .r_valid        (r_valid),
        .b_valid        (b_valid),
        .bus_busy       (bus_busy),
        .req_ready      (req_ready),
        .cur_req        (cur_req),
        .store_value    (store_value),
        .issue_read     (issue_read),
        .issue_write    (issue_write),
        .bus_addr       (bus_addr),
        .resp_valid     (resp_valid),
        .resp_value     (resp_value),
        .resp_exception (resp_exception)
    );

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
// Testbench memory model for the reduced AXI port, random ready and response delays
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire dcache_pkg::bus_addr_t ar,
    input  wire dcache_pkg::bus_addr_t aw,
    input  wire dcache_pkg::bus_w_t    w,
    output logic                      ar_ready,
    output logic                      aw_ready,
    output logic                      w_ready,
    output logic                      r_valid,
    output dcache_pkg::xlen_t         r_data,
    output logic                      b_valid,
    output int                        txn_count
);

    localparam dcache_pkg::xlen_t BASE = 64'h0000_0000_8000_0000;

    dcache_pkg::xlen_t mem [16];
    dcache_pkg::xlen_t rd_addr;
    dcache_pkg::xlen_t wr_addr;
    dcache_pkg::xlen_t wr_data;
    dcache_pkg::strb_t wr_strb;
    logic [31:0]       delay_state = 32'h232ab41c;

    // Memory delay of 0 to 3 cycles
    function automatic int pick_delay();
        delay_state = delay_state ^ (delay_state << 13);
        delay_state = delay_state ^ (delay_state >> 17);
        delay_state = delay_state ^ (delay_state << 5);
        return int'(delay_state[1:0]);
    endfunction

    task automatic serve_read();
        int d;
        d = pick_delay();
        #1;
        repeat (d) begin
            @(posedge clk);
            #2;
        end
        ar_ready = 1'b1;
        @(posedge clk);
        rd_addr = ar.addr;
        #2 ar_ready = 1'b0;
        txn_count = txn_count + 1;
        d = pick_delay();
        repeat (d) begin
            @(posedge clk);
            #2;
        end
        r_data  = mem[rd_addr[6:3]];
        r_valid = 1'b1;
        @(posedge clk);
        #2 r_valid = 1'b0;
    endtask

    task automatic serve_write();
        int da;
        int dw;
        int d;
        da = pick_delay();
        dw = pick_delay();
        #1;
        fork
            begin
                repeat (da) begin
                    @(posedge clk);
                    #2;
                end
                aw_ready = 1'b1;
                @(posedge clk);
                wr_addr = aw.addr;
                #2 aw_ready = 1'b0;
            end
            begin
                repeat (dw) begin
                    @(posedge clk);
                    #2;
                end
                w_ready = 1'b1;
                @(posedge clk);
                wr_data = w.data;
                wr_strb = w.strb;
                #2 w_ready = 1'b0;
            end
        join
        for (int k = 0; k < 8; k++) begin
            if (wr_strb[k]) mem[wr_addr[6:3]][k*8 +: 8] = wr_data[k*8 +: 8];
        end
        txn_count = txn_count + 1;
        d = pick_delay();
        repeat (d) begin
            @(posedge clk);
            #2;
        end
        b_valid = 1'b1;
        @(posedge clk);
        #2 b_valid = 1'b0;
    endtask

    initial begin
        ar_ready  = 1'b0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        b_valid   = 1'b0;
        txn_count = 0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = (BASE + dcache_pkg::xlen_t'(i * 8)) * 64'h9e37_79b9_7f4a_7c15;
        end
        forever begin
            @(posedge clk);
            #1;
            if (rstn && ar.valid) serve_read();
            else if (rstn && aw.valid) serve_write();  // AW and W rise together
        end
    end

endmodule

`default_nettype wire

//--- tb_dcache_uncached.sv
// Testbench top for the uncached data-memory unit with reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_uncached;

    localparam int                NREQ       = 200;
    localparam int                MAX_CYCLES = NREQ * 20;
    localparam dcache_pkg::xlen_t BASE       = 64'h0000_0000_8000_0000;

    logic                   clk = 1'b0;
    logic                   rstn;
    logic                   req_valid;
    dcache_pkg::mem_req_t   req;
    logic                   req_ready;
    logic                   resp_valid;
    dcache_pkg::xlen_t      resp_value;
    dcache_pkg::exception_t resp_exception;
    dcache_pkg::bus_addr_t  ar;
    dcache_pkg::bus_addr_t  aw;
    dcache_pkg::bus_w_t     w;
    logic                   ar_ready;
    logic                   aw_ready;
    logic                   w_ready;
    logic                   r_valid;
    dcache_pkg::xlen_t      r_data;
    logic                   b_valid;
    int                     txn_count;

    dcache_pkg::xlen_t      shadow [16];
    dcache_pkg::xlen_t      exp_value_q [$];
    dcache_pkg::exception_t exp_exc_q [$];
    int                     exp_txn_q [$];
    dcache_pkg::xlen_t      exp_value;
    dcache_pkg::exception_t exp_exc;
    int                     exp_txn;
    int                     n_resp = 0;
    int                     cycles = 0;
    logic [31:0]            rng_state = 32'h232ab41c;

    dcache_pkg::amo_funct_t amo_codes [9] = '{dcache_pkg::AMO_SWAP, dcache_pkg::AMO_ADD,
        dcache_pkg::AMO_XOR, dcache_pkg::AMO_AND, dcache_pkg::AMO_OR, dcache_pkg::AMO_MIN,
        dcache_pkg::AMO_MAX, dcache_pkg::AMO_MINU, dcache_pkg::AMO_MAXU};

    dcache_uncached uut (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_value(resp_value), .resp_exception(resp_exception),
        .ar(ar), .aw(aw), .w(w), .ar_ready(ar_ready), .aw_ready(aw_ready), .w_ready(w_ready),
        .r_valid(r_valid), .r_data(r_data), .b_valid(b_valid)
    );

    tb_axi_mem u_mem (
        .clk(clk), .rstn(rstn), .ar(ar), .aw(aw), .w(w), .ar_ready(ar_ready),
        .aw_ready(aw_ready), .w_ready(w_ready), .r_valid(r_valid), .r_data(r_data),
        .b_valid(b_valid), .txn_count(txn_count)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic dcache_pkg::xlen_t amo_expected(input dcache_pkg::amo_funct_t f,
                                                       input dcache_pkg::xlen_t a,
                                                       input dcache_pkg::xlen_t b);
        case (f)
            dcache_pkg::AMO_SWAP: return b;
            dcache_pkg::AMO_ADD:  return a + b;
            dcache_pkg::AMO_XOR:  return a ^ b;
            dcache_pkg::AMO_AND:  return a & b;
            dcache_pkg::AMO_OR:   return a | b;
            dcache_pkg::AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            dcache_pkg::AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
            dcache_pkg::AMO_MINU: return (a < b) ? a : b;
            default:              return (a > b) ? a : b;
        endcase
    endfunction

    function automatic void shadow_write(input logic [3:0] idx, input logic [2:0] off,
                                         input int nbytes, input dcache_pkg::xlen_t v);
        for (int k = 0; k < nbytes; k++) begin
            shadow[idx][(int'(off) + k) * 8 +: 8] = v[k*8 +: 8];
        end
    endfunction

    // Computes the expected response and updates the shadow memory on writes
    function automatic dcache_pkg::xlen_t ref_access(input dcache_pkg::mem_req_t r,
                                                     output dcache_pkg::exception_t exc);
        logic [3:0]        idx;
        logic [2:0]        off;
        int                nbytes;
        logic              sgn;
        dcache_pkg::xlen_t raw;
        dcache_pkg::xlen_t loaded;
        dcache_pkg::xlen_t opnd;
        idx    = r.address[6:3];
        off    = r.address[2:0];
        nbytes = 1 << r.size;
        exc    = '0;
        if ((int'(off) % nbytes) != 0) begin
            exc.valid = 1'b1;
            exc.cause = (r.op == dcache_pkg::MEM_LOAD || r.op == dcache_pkg::MEM_LR) ?
                        4'd4 : 4'd6;
            exc.tval  = r.address;
            return '0;
        end
        raw = shadow[idx] >> (8 * int'(off));
        sgn = r.op == dcache_pkg::MEM_AMO || !r.is_unsigned;
        case (nbytes)
            1:       loaded = {{56{sgn & raw[7]}}, raw[7:0]};
            2:       loaded = {{48{sgn & raw[15]}}, raw[15:0]};
            4:       loaded = {{32{sgn & raw[31]}}, raw[31:0]};
            default: loaded = raw;
        endcase
        if (r.op == dcache_pkg::MEM_LOAD || r.op == dcache_pkg::MEM_LR) return loaded;
        if (r.op == dcache_pkg::MEM_AMO) begin
            opnd = (nbytes == 4) ? {{32{r.value[31]}}, r.value[31:0]} : r.value;
            shadow_write(idx, off, nbytes, amo_expected(r.amo_funct, loaded, opnd));
            return loaded;  // Old memory value
        end
        shadow_write(idx, off, nbytes, r.value);
        return '0;
    endfunction

    task automatic fail_run(input string what);
        $display("Error: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input dcache_pkg::xlen_t got,
                               input dcache_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_exception(input dcache_pkg::exception_t got,
                                   input dcache_pkg::exception_t exp);
        if (got !== exp) begin
            $display("[FAIL] resp_exception cause %h tval %h expected cause %h tval %h",
                     got.cause, got.tval, exp.cause, exp.tval);
            $display("TESTBENCH FAILED");
            $fatal(1, "exception mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // Checks each response 1 ns after the edge
    always @(posedge clk) begin
        #1;
        if (rstn && (resp_valid || resp_exception.valid)) begin
            if (exp_exc_q.size() == 0) begin
                fail_run("response arrived with no request outstanding");
            end else if (resp_valid && resp_exception.valid) begin
                fail_run("resp_valid and exception valid high in the same cycle");
            end else begin
                exp_value = exp_value_q.pop_front();
                exp_exc   = exp_exc_q.pop_front();
                exp_txn   = exp_txn_q.pop_front();
                if (exp_exc.valid && !resp_exception.valid) begin
                    fail_run("expected an exception but got a normal response");
                end else if (!exp_exc.valid && !resp_valid) begin
                    fail_run("unexpected exception on an aligned request");
                end else if (exp_exc.valid) begin
                    check_exception(resp_exception, exp_exc);
                    if (txn_count != exp_txn) fail_run("bus traffic for a misaligned request");
                end else begin
                    check_value("resp_value", resp_value, exp_value);
                end
                n_resp = n_resp + 1;
            end
        end else if (rstn && req_ready && !req_valid && exp_exc_q.size() != 0) begin
            fail_run("req_ready high while an accepted request has no response");
        end
    end

    initial begin
        dcache_pkg::mem_req_t   r;
        dcache_pkg::exception_t e;
        dcache_pkg::xlen_t      v;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        req.amo_funct = dcache_pkg::AMO_ADD;
        repeat (4) @(posedge clk);
        #2 rstn = 1'b1;
        @(posedge clk);
        #1;
        if (!req_ready || resp_valid || resp_exception.valid ||
            ar.valid || aw.valid || w.valid) begin
            fail_run("idle outputs wrong after reset");
        end
        for (int i = 0; i < 16; i++) shadow[i] = u_mem.mem[i];

        for (int n = 0; n < NREQ; n++) begin
            @(posedge clk);
            #2;
            r             = '0;
            r.op          = dcache_pkg::mem_op_t'(3'(rand_next() % 5));
            r.size        = 2'(rand_next());
            if (r.op == dcache_pkg::MEM_AMO) r.size = {1'b1, r.size[0]};  // Word or double
            r.is_unsigned = rand_next() % 2 == 1;
            r.amo_funct   = amo_codes[rand_next() % 9];
            r.value       = {rand_next(), rand_next()};
            r.address     = BASE + dcache_pkg::xlen_t'(rand_next() % 16) * 8;
            if (rand_next() % 8 == 0) begin
                r.address[2:0] = 3'(rand_next());       // Likely misaligned
            end else begin
                r.address[2:0] = 3'((rand_next() % (8 >> r.size)) << r.size);
            end
            v = ref_access(r, e);
            exp_value_q.push_back(v);
            exp_exc_q.push_back(e);
            exp_txn_q.push_back(txn_count);
            req       = r;
            req_valid = 1'b1;
            while (!req_ready) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2 req_valid = 1'b0;
            while (n_resp <= n) @(posedge clk);
        end

        repeat (4) @(posedge clk);  // Catch a stray second response
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
dcache_pkg.sv
lsu_align.sv
amo_alu.sv
bus_issue.sv
uncached_ctrl.sv
dcache_uncached.sv
tb_axi_mem.sv
tb_dcache_uncached.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status carries pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_dcache_uncached \
    -o sim_dcache

./obj_dir/sim_dcache
